/* ex_unit.f */
+incdir+.
ex_pkg.sv
ex_operand_sel.sv
ex_alu.sv
ex_mul.sv
ex_div.sv
ex_wb_arbiter.sv
ex_unit.sv
ex_unit_properties.sv
tb_ex_unit.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the execute stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_ex_unit -f ex_unit.f \
    || { echo "Verilator build failed"; exit 1; }

out="$(./obj_dir/Vtb_ex_unit 2>&1)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Simulation passed" && exit 0 || exit 1

/* tb_ex_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module tb_ex_unit;
    localparam int XLEN       = `EX_XLEN;
    localparam int NTAG       = 1 << `EX_TAG_W;
    localparam int NUM_ISSUES = 3000;
    localparam int MAX_CYCLES = NUM_ISSUES * 70 + 1000;
    localparam logic [XLEN-1:0] MIN_NEG = {1'b1, {(XLEN-1){1'b0}}};

    logic                 clk = 1'b0;
    logic                 rst = 1'b1;
    logic                 issue_valid = 1'b0;
    ex_pkg::alu_op_t      op = ex_pkg::op_add;
    ex_pkg::sel_a_t       sel_a = ex_pkg::sel_a_rs1;
    ex_pkg::sel_b_t       sel_b = ex_pkg::sel_b_rs2;
    logic                 word_a = 1'b0;
    logic [XLEN-1:0]      pc = '0;
    logic [XLEN-1:0]      rs1 = '0;
    logic [XLEN-1:0]      rs2 = '0;
    logic [XLEN-1:0]      csr = '0;
    logic [XLEN-1:0]      imm = '0;
    logic [`EX_TAG_W-1:0] tag = '0;
    logic                 mul_busy;
    logic                 div_busy;
    logic                 res_valid;
    logic [`EX_TAG_W-1:0] res_tag;
    logic [XLEN-1:0]      res_data;

    // scoreboard indexed by tag
    logic                 pending [NTAG];
    logic [XLEN-1:0]      exp_data [NTAG];
    ex_pkg::unit_t        exp_unit [NTAG];
    int                   exp_cycle [NTAG];
    logic [63:0]          rng_state;
    logic [`EX_TAG_W-1:0] next_tag;
    logic                 mul_pending;
    logic                 div_pending;
    logic                 mul_freed;
    int                   cycle;
    int                   issued;
    int                   pend_count;
    int                   checks;
    int                   errors;

    ex_unit DUT (
        .clk(clk), .rst(rst), .issue_valid(issue_valid), .op(op),
        .sel_a(sel_a), .sel_b(sel_b), .word_a(word_a),
        .pc(pc), .rs1(rs1), .rs2(rs2), .csr(csr), .imm(imm), .tag(tag),
        .mul_busy(mul_busy), .div_busy(div_busy),
        .res_valid(res_valid), .res_tag(res_tag), .res_data(res_data)
    );

    bind ex_unit ex_unit_properties u_properties (
        .clk(clk), .rst(rst), .mul_start(mul_start), .div_start(div_start),
        .mul_busy(mul_busy), .div_busy(div_busy),
        .mul_done(mul_done), .mul_grant(mul_grant),
        .mul_done_tag(mul_done_tag), .mul_done_data(mul_done_data),
        .div_done(div_done), .div_grant(div_grant),
        .div_done_tag(div_done_tag), .div_done_data(div_done_data),
        .res_valid(res_valid), .res_tag(res_tag)
    );

    always #10 clk = ~clk;

    function automatic logic [63:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 7);
        rng_state = rng_state ^ (rng_state << 17);
        return rng_state;
    endfunction

    // favours the values that break arithmetic corners
    function automatic logic [XLEN-1:0] pick_value();
        logic [63:0] r;
        r = next_rand();
        case (r[2:0])
            3'd0:    return '0;
            3'd1:    return '1;
            3'd2:    return MIN_NEG;
            3'd3:    return 64'd1;
            default: return next_rand();
        endcase
    endfunction

    function automatic logic [XLEN-1:0] select_a(input ex_pkg::sel_a_t s, input logic word,
            input logic [XLEN-1:0] pc_v, input logic [XLEN-1:0] rs1_v);
        if (s == ex_pkg::sel_a_pc) begin
            return pc_v;
        end else if (word) begin
            return {32'd0, rs1_v[31:0]};
        end else begin
            return rs1_v;
        end
    endfunction

    function automatic logic [XLEN-1:0] select_b(input ex_pkg::sel_b_t s,
            input logic [XLEN-1:0] rs2_v, input logic [XLEN-1:0] csr_v,
            input logic [XLEN-1:0] imm_v);
        case (s)
            ex_pkg::sel_b_rs2: return rs2_v;
            ex_pkg::sel_b_csr: return csr_v;
            default:           return imm_v;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] model_result(input ex_pkg::alu_op_t f,
            input logic [XLEN-1:0] a, input logic [XLEN-1:0] b, input logic word);
        logic signed [XLEN-1:0] sa;
        logic signed [XLEN-1:0] sb;
        logic signed [31:0]     aw;
        logic [5:0]             sh;
        logic                   ovf;
        sa  = a;
        sb  = b;
        aw  = a[31:0];
        sh  = b[5:0];
        ovf = (a == MIN_NEG) && (b == '1);
        case (f)
            ex_pkg::op_add:   return a + b;
            ex_pkg::op_sub:   return a - b;
            ex_pkg::op_ret_a: return a;
            ex_pkg::op_ret_b: return b;
            ex_pkg::op_xor:   return a ^ b;
            ex_pkg::op_or:    return a | b;
            ex_pkg::op_and:   return a & b;
            ex_pkg::op_sll:   return a << sh;
            ex_pkg::op_srl:   return a >> sh;
            ex_pkg::op_sra: begin
                if (word) begin
                    return {32'd0, aw >>> sh};
                end else begin
                    return sa >>> sh;
                end
            end
            ex_pkg::op_slt:   return {63'd0, sa < sb};
            ex_pkg::op_sltu:  return {63'd0, a < b};
            ex_pkg::op_eq:    return {63'd0, a == b};
            ex_pkg::op_ge:    return {63'd0, sa >= sb};
            ex_pkg::op_geu:   return {63'd0, a >= b};
            ex_pkg::op_mul:   return a * b;
            ex_pkg::op_divu:  return (b == '0) ? '1 : a / b;
            ex_pkg::op_remu:  return (b == '0) ? a : a % b;
            ex_pkg::op_div: begin
                if (b == '0) begin
                    return '1;
                end else if (ovf) begin
                    return a;
                end else begin
                    return sa / sb;
                end
            end
            ex_pkg::op_rem: begin
                if (b == '0) begin
                    return a;
                end else if (ovf) begin
                    return '0;
                end else begin
                    return sa % sb;
                end
            end
            default:          return '0;
        endcase
    endfunction

    task automatic check_result();
        checks++;
        assert (pending[res_tag]) else begin
            errors++;
            $display("Error at %0t: result for tag %0d which is not in flight", $time, res_tag);
        end
        if (pending[res_tag]) begin
            assert (res_data == exp_data[res_tag]) else begin
                errors++;
                $display("Error at %0t: res_data tag %0d got %h expected %h",
                         $time, res_tag, res_data, exp_data[res_tag]);
            end
            // alu results are never stalled
            if (exp_unit[res_tag] == ex_pkg::unit_alu) begin
                assert (cycle == exp_cycle[res_tag]) else begin
                    errors++;
                    $display("Error at %0t: res_valid cycle tag %0d got %0d expected %0d",
                             $time, res_tag, cycle, exp_cycle[res_tag]);
                end
            end
            if (exp_unit[res_tag] == ex_pkg::unit_mul) begin
                mul_pending = 1'b0;
                mul_freed   = 1'b1;
            end
            if (exp_unit[res_tag] == ex_pkg::unit_div) begin
                div_pending = 1'b0;
            end
            pending[res_tag] = 1'b0;
            pend_count--;
        end
    endtask

    task automatic check_busy();
        assert (mul_busy == mul_pending) else begin
            errors++;
            $display("Error at %0t: mul_busy got %b expected %b", $time, mul_busy, mul_pending);
        end
        assert (div_busy == div_pending) else begin
            errors++;
            $display("Error at %0t: div_busy got %b expected %b", $time, div_busy, div_pending);
        end
    endtask

    task automatic drive_issue();
        logic [63:0]     r;
        ex_pkg::alu_op_t f;
        ex_pkg::unit_t   u;
        logic            refill;
        r = next_rand();
        refill = mul_freed;
        mul_freed = 1'b0;
        issue_valid = 1'b0;
        if (r[0] || issued >= NUM_ISSUES) begin
            return;
        end
        f = ex_pkg::alu_op_t'(5'(r[63:32] % 20));
        // often reissue a multiply in the cycle its predecessor frees the unit
        if (refill && r[16]) begin
            f = ex_pkg::op_mul;
        end
        u = ex_pkg::op_unit(f);
        if ((u == ex_pkg::unit_mul && mul_busy) || (u == ex_pkg::unit_div && div_busy)) begin
            return;
        end
        if (pending[next_tag]) begin
            next_tag = next_tag + 1'b1;
            return;
        end
        op     = f;
        sel_a  = ex_pkg::sel_a_t'(r[1]);
        sel_b  = ex_pkg::sel_b_t'(2'(r[15:8] % 3));
        word_a = r[2];
        pc     = pick_value();
        rs1    = pick_value();
        rs2    = pick_value();
        csr    = pick_value();
        imm    = pick_value();
        case (r[5:3])
            // zero divisor
            3'd0: begin
                rs2 = '0;
                csr = '0;
                imm = '0;
            end
            // all-ones b against min or all-ones a covers the signed overflow
            3'd1: begin
                sel_a  = ex_pkg::sel_a_rs1;
                word_a = 1'b0;
                rs1    = r[6] ? MIN_NEG : '1;
                rs2    = '1;
                csr    = '1;
                imm    = '1;
            end
            default: begin
            end
        endcase
        tag = next_tag;
        exp_data[next_tag]  = model_result(f, select_a(sel_a, word_a, pc, rs1),
                                           select_b(sel_b, rs2, csr, imm), word_a);
        exp_unit[next_tag]  = u;
        exp_cycle[next_tag] = cycle + 2;
        pending[next_tag]   = 1'b1;
        pend_count++;
        if (u == ex_pkg::unit_mul) begin
            mul_pending = 1'b1;
        end
        if (u == ex_pkg::unit_div) begin
            div_pending = 1'b1;
        end
        issued++;
        next_tag    = next_tag + 1'b1;
        issue_valid = 1'b1;
    endtask

    initial begin
        rng_state   = 64'd1083;
        next_tag    = '0;
        mul_pending = 1'b0;
        div_pending = 1'b0;
        mul_freed   = 1'b0;
        cycle       = 0;
        issued      = 0;
        pend_count  = 0;
        checks      = 0;
        errors      = 0;
        for (int i = 0; i < NTAG; i++) begin
            pending[i]   = 1'b0;
            exp_data[i]  = '0;
            exp_unit[i]  = ex_pkg::unit_alu;
            exp_cycle[i] = 0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // outputs are sampled and inputs driven on the falling edge
        while ((issued < NUM_ISSUES || pend_count > 0) && cycle < MAX_CYCLES) begin
            @(negedge clk);
            cycle++;
            if (res_valid) begin
                check_result();
            end
            check_busy();
            drive_issue();
        end
        issue_valid = 1'b0;

        if (cycle >= MAX_CYCLES) begin
            errors++;
            $display("Timeout: results still missing after %0d cycles", MAX_CYCLES);
        end
        if (pend_count > 0) begin
            errors++;
            $display("Error: %0d issued tags never returned a result", pend_count);
        end
        $display("Results checked %0d, issued %0d, errors %0d", checks, issued, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* ex_unit_properties.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module ex_unit_properties (
    input logic                  clk,
    input logic                  rst,
    input logic                  mul_start,
    input logic                  div_start,
    input logic                  mul_busy,
    input logic                  div_busy,
    input logic                  mul_done,
    input logic                  mul_grant,
    input logic [`EX_TAG_W-1:0]  mul_done_tag,
    input logic [`EX_XLEN-1:0]   mul_done_data,
    input logic                  div_done,
    input logic                  div_grant,
    input logic [`EX_TAG_W-1:0]  div_done_tag,
    input logic [`EX_XLEN-1:0]   div_done_data,
    input logic                  res_valid,
    input logic [`EX_TAG_W-1:0]  res_tag
);
    // dispatcher must respect busy
    mul_start_idle: assert property (@(posedge clk) disable iff (rst) mul_start |-> !mul_busy)
        else $error("multiplier started while still busy");
    div_start_idle: assert property (@(posedge clk) disable iff (rst) div_start |-> !div_busy)
        else $error("divider started while still busy");

    res_once: assert property (@(posedge clk) disable iff (rst)
        res_valid |=> !(res_valid && (res_tag == $past(res_tag))))
        else $error("writeback strobe repeated for the same tag");

    // a result waiting for grant must not move
    mul_hold: assert property (@(posedge clk) disable iff (rst)
        (mul_done && !mul_grant) |=> (mul_done && $stable(mul_done_data) && $stable(mul_done_tag)))
        else $error("multiplier result changed while waiting for grant");
    div_hold: assert property (@(posedge clk) disable iff (rst)
        (div_done && !div_grant) |=> (div_done && $stable(div_done_data) && $stable(div_done_tag)))
        else $error("divider result changed while waiting for grant");

    res_after_reset: assert property (@(posedge clk) rst |=> !res_valid)
        else $error("writeback strobe high in the cycle after reset");

endmodule

`default_nettype wire

/* ex_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module ex_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  issue_valid,
    input  ex_pkg::alu_op_t       op,
    input  ex_pkg::sel_a_t        sel_a,
    input  ex_pkg::sel_b_t        sel_b,
    input  logic                  word_a,
    input  logic [`EX_XLEN-1:0]   pc,
    input  logic [`EX_XLEN-1:0]   rs1,
    input  logic [`EX_XLEN-1:0]   rs2,
    input  logic [`EX_XLEN-1:0]   csr,
    input  logic [`EX_XLEN-1:0]   imm,
    input  logic [`EX_TAG_W-1:0]  tag,
    output logic                  mul_busy,
    output logic                  div_busy,
    output logic                  res_valid,
    output logic [`EX_TAG_W-1:0]  res_tag,
    output logic [`EX_XLEN-1:0]   res_data
);
    logic [`EX_XLEN-1:0]  a;
    logic [`EX_XLEN-1:0]  b;
    ex_pkg::unit_t        issue_unit;
    logic                 alu_start;
    logic                 mul_start;
    logic                 div_start;

    logic                 alu_done;
    logic [`EX_TAG_W-1:0] alu_done_tag;
    logic [`EX_XLEN-1:0]  alu_done_data;
    logic                 mul_done;
    logic [`EX_TAG_W-1:0] mul_done_tag;
    logic [`EX_XLEN-1:0]  mul_done_data;
    logic                 mul_grant;
    logic                 div_done;
    logic [`EX_TAG_W-1:0] div_done_tag;
    logic [`EX_XLEN-1:0]  div_done_data;
    logic                 div_grant;

    // one start per issue, picked by operation class
    assign issue_unit = ex_pkg::op_unit(op);
    assign alu_start  = issue_valid && (issue_unit == ex_pkg::unit_alu);
    assign mul_start  = issue_valid && (issue_unit == ex_pkg::unit_mul);
    assign div_start  = issue_valid && (issue_unit == ex_pkg::unit_div);

    ex_operand_sel u_operand_sel (
        .sel_a(sel_a), .sel_b(sel_b), .word_a(word_a),
        .pc(pc), .rs1(rs1), .rs2(rs2), .csr(csr), .imm(imm),
        .a(a), .b(b)
    );

    ex_alu u_alu (
        .clk(clk), .rst(rst), .start(alu_start), .op(op),
        .a(a), .b(b), .word_a(word_a), .tag(tag),
        .done(alu_done), .done_tag(alu_done_tag), .done_data(alu_done_data)
    );

    ex_mul u_mul (
        .clk(clk), .rst(rst), .start(mul_start),
        .a(a), .b(b), .tag(tag), .grant(mul_grant), .busy(mul_busy),
        .done(mul_done), .done_tag(mul_done_tag), .done_data(mul_done_data)
    );

    ex_div u_div (
        .clk(clk), .rst(rst), .start(div_start), .op(op),
        .a(a), .b(b), .tag(tag), .grant(div_grant), .busy(div_busy),
        .done(div_done), .done_tag(div_done_tag), .done_data(div_done_data)
    );

    ex_wb_arbiter u_wb_arbiter (
        .clk(clk), .rst(rst),
        .alu_done(alu_done), .alu_done_tag(alu_done_tag), .alu_done_data(alu_done_data),
        .mul_done(mul_done), .mul_done_tag(mul_done_tag), .mul_done_data(mul_done_data),
        .div_done(div_done), .div_done_tag(div_done_tag), .div_done_data(div_done_data),
        .mul_grant(mul_grant), .div_grant(div_grant),
        .res_valid(res_valid), .res_tag(res_tag), .res_data(res_data)
    );

endmodule

`default_nettype wire

/* ex_wb_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module ex_wb_arbiter (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  alu_done,
    input  logic [`EX_TAG_W-1:0]  alu_done_tag,
    input  logic [`EX_XLEN-1:0]   alu_done_data,
    input  logic                  mul_done,
    input  logic [`EX_TAG_W-1:0]  mul_done_tag,
    input  logic [`EX_XLEN-1:0]   mul_done_data,
    input  logic                  div_done,
    input  logic [`EX_TAG_W-1:0]  div_done_tag,
    input  logic [`EX_XLEN-1:0]   div_done_data,
    output logic                  mul_grant,
    output logic                  div_grant,
    output logic                  res_valid,
    output logic [`EX_TAG_W-1:0]  res_tag,
    output logic [`EX_XLEN-1:0]   res_data
);
    logic                 any_done;
    logic [`EX_TAG_W-1:0] win_tag;
    logic [`EX_XLEN-1:0]  win_data;

    // alu never waits, its done lasts a single cycle
    assign mul_grant = mul_done & ~alu_done;
    assign div_grant = div_done & ~alu_done & ~mul_done;
    assign any_done  = alu_done | mul_done | div_done;

    always_comb begin
        if (alu_done) begin
            win_tag  = alu_done_tag;
            win_data = alu_done_data;
        end else if (mul_done) begin
            win_tag  = mul_done_tag;
            win_data = mul_done_data;
        end else begin
            win_tag  = div_done_tag;
            win_data = div_done_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= any_done;
        end
    end

    always_ff @(posedge clk) begin
        if (any_done) begin
            res_tag  <= win_tag;
            res_data <= win_data;
        end
    end

endmodule

`default_nettype wire

/* ex_div.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module ex_div (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  ex_pkg::alu_op_t       op,
    input  logic [`EX_XLEN-1:0]   a,
    input  logic [`EX_XLEN-1:0]   b,
    input  logic [`EX_TAG_W-1:0]  tag,
    input  logic                  grant,
    output logic                  busy,
    output logic                  done,
    output logic [`EX_TAG_W-1:0]  done_tag,
    output logic [`EX_XLEN-1:0]   done_data
);
    localparam int XLEN = `EX_XLEN;
    localparam int CW   = $clog2(XLEN);
    localparam logic [CW-1:0] LAST = CW'(XLEN - 1);

    logic            running;
    logic [CW-1:0]   cnt;
    logic [XLEN-1:0] rem_q;
    logic [XLEN-1:0] quo_q;
    logic [XLEN-1:0] dvs_q;
    logic            neg_q;
    logic            neg_r;
    logic            div_zero;
    logic            sel_rem;
    logic [`EX_TAG_W-1:0] tag_q;

    logic            is_signed;
    logic            sa;
    logic            sb;
    logic [XLEN-1:0] abs_a;
    logic [XLEN-1:0] abs_b;

    logic [XLEN-1:0] rem_in;
    logic [XLEN-1:0] quo_in;
    logic [XLEN-1:0] dvs_in;
    logic [XLEN:0]   rem_sh;
    logic            fits;
    logic [XLEN-1:0] rem_nx;
    logic [XLEN-1:0] quo_nx;
    logic [XLEN-1:0] quo_fin;
    logic [XLEN-1:0] rem_fin;

    assign is_signed = (op == ex_pkg::op_div) || (op == ex_pkg::op_rem);
    assign sa    = is_signed & a[XLEN-1];
    assign sb    = is_signed & b[XLEN-1];
    assign abs_a = sa ? -a : a;
    assign abs_b = sb ? -b : b;

    // one restoring step, the first one runs in the start cycle
    always_comb begin
        rem_in = start ? '0 : rem_q;
        quo_in = start ? abs_a : quo_q;
        dvs_in = start ? abs_b : dvs_q;
        rem_sh = {rem_in, quo_in[XLEN-1]};
        fits   = rem_sh >= {1'b0, dvs_in};
        rem_nx = fits ? rem_sh[XLEN-1:0] - dvs_in : rem_sh[XLEN-1:0];
        quo_nx = {quo_in[XLEN-2:0], fits};
    end

    // min / -1 already yields quotient a and remainder 0 on magnitudes,
    // and x / 0 leaves |a| as remainder, so only the quotient needs forcing
    always_comb begin
        quo_fin = div_zero ? '1 : (neg_q ? -quo_nx : quo_nx);
        rem_fin = neg_r ? -rem_nx : rem_nx;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            busy    <= 1'b0;
            done    <= 1'b0;
            cnt     <= '0;
        end else begin
            if (start) begin
                running <= 1'b1;
                busy    <= 1'b1;
                cnt     <= CW'(1);
            end else if (running) begin
                cnt <= cnt + 1'b1;
                if (cnt == LAST) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
            if (done && grant) begin
                done <= 1'b0;
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start || running) begin
            rem_q <= rem_nx;
            quo_q <= quo_nx;
            dvs_q <= dvs_in;
        end
        if (start) begin
            neg_q    <= sa ^ sb;
            neg_r    <= sa;
            div_zero <= (b == '0);
            sel_rem  <= (op == ex_pkg::op_rem) || (op == ex_pkg::op_remu);
            tag_q    <= tag;
        end
        if (running && cnt == LAST) begin
            done_data <= sel_rem ? rem_fin : quo_fin;
        end
    end

    assign done_tag = tag_q;

endmodule

`default_nettype wire

/* ex_mul.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module ex_mul (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  logic [`EX_XLEN-1:0]   a,
    input  logic [`EX_XLEN-1:0]   b,
    input  logic [`EX_TAG_W-1:0]  tag,
    input  logic                  grant,
    output logic                  busy,
    output logic                  done,
    output logic [`EX_TAG_W-1:0]  done_tag,
    output logic [`EX_XLEN-1:0]   done_data
);
    localparam int XLEN   = `EX_XLEN;
    localparam int CHUNK  = `EX_MUL_CHUNK;
    localparam int NCHUNK = XLEN / CHUNK;
    localparam int CW     = $clog2(NCHUNK);
    localparam logic [CW-1:0] LAST = CW'(NCHUNK - 1);

    logic            running;
    logic [CW-1:0]   cnt;
    logic [XLEN-1:0] mcand;
    logic [XLEN-1:0] mplier;
    logic [XLEN-1:0] acc;
    logic [`EX_TAG_W-1:0] tag_q;

    logic [XLEN-1:0] step_mcand;
    logic [XLEN-1:0] step_mplier;
    logic [XLEN-1:0] step_acc;
    logic [XLEN-1:0] acc_nx;

    // first chunk is taken straight from the issue operands
    always_comb begin
        step_mcand  = start ? a : mcand;
        step_mplier = start ? b : mplier;
        step_acc    = start ? '0 : acc;
        acc_nx = step_acc + step_mcand * {{(XLEN-CHUNK){1'b0}}, step_mplier[CHUNK-1:0]};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            busy    <= 1'b0;
            done    <= 1'b0;
            cnt     <= '0;
        end else begin
            if (start) begin
                running <= 1'b1;
                busy    <= 1'b1;
                cnt     <= CW'(1);
            end else if (running) begin
                cnt <= cnt + 1'b1;
                if (cnt == LAST) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
            if (done && grant) begin
                done <= 1'b0;
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start || running) begin
            mcand  <= step_mcand << CHUNK;
            mplier <= step_mplier >> CHUNK;
            acc    <= acc_nx;
        end
        if (start) begin
            tag_q <= tag;
        end
    end

    // acc and tag_q stay put until the next start, which waits for busy to drop
    assign done_data = acc;
    assign done_tag  = tag_q;

endmodule

`default_nettype wire

/* ex_alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module ex_alu (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  ex_pkg::alu_op_t       op,
    input  logic [`EX_XLEN-1:0]   a,
    input  logic [`EX_XLEN-1:0]   b,
    input  logic                  word_a,
    input  logic [`EX_TAG_W-1:0]  tag,
    output logic                  done,
    output logic [`EX_TAG_W-1:0]  done_tag,
    output logic [`EX_XLEN-1:0]   done_data
);
    localparam int XLEN = `EX_XLEN;
    localparam int HALF = XLEN / 2;

    logic [XLEN-1:0] result;
    logic [5:0]      shamt;
    logic [HALF-1:0] sra_word;
    logic [XLEN-1:0] sra_full;

    assign shamt = b[5:0];
    assign sra_word = $signed(a[HALF-1:0]) >>> shamt;
    assign sra_full = $signed(a) >>> shamt;

    always_comb begin
        case (op)
            ex_pkg::op_add:   result = a + b;
            ex_pkg::op_sub:   result = a - b;
            ex_pkg::op_ret_a: result = a;
            ex_pkg::op_ret_b: result = b;
            ex_pkg::op_xor:   result = a ^ b;
            ex_pkg::op_or:    result = a | b;
            ex_pkg::op_and:   result = a & b;
            ex_pkg::op_sll:   result = a << shamt;
            ex_pkg::op_srl:   result = a >> shamt;
            // sign fill of the word form stops at bit 31
            ex_pkg::op_sra:   result = word_a ? {{HALF{1'b0}}, sra_word} : sra_full;
            ex_pkg::op_slt:   result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ex_pkg::op_sltu:  result = {{(XLEN-1){1'b0}}, a < b};
            ex_pkg::op_eq:    result = {{(XLEN-1){1'b0}}, a == b};
            ex_pkg::op_ge:    result = {{(XLEN-1){1'b0}}, $signed(a) >= $signed(b)};
            ex_pkg::op_geu:   result = {{(XLEN-1){1'b0}}, a >= b};
            default:          result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            done <= 1'b0;
        end else begin
            done <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            done_tag  <= tag;
            done_data <= result;
        end
    end

endmodule

`default_nettype wire

/* ex_operand_sel.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module ex_operand_sel (
    input  ex_pkg::sel_a_t       sel_a,
    input  ex_pkg::sel_b_t       sel_b,
    input  logic                 word_a,
    input  logic [`EX_XLEN-1:0]  pc,
    input  logic [`EX_XLEN-1:0]  rs1,
    input  logic [`EX_XLEN-1:0]  rs2,
    input  logic [`EX_XLEN-1:0]  csr,
    input  logic [`EX_XLEN-1:0]  imm,
    output logic [`EX_XLEN-1:0]  a,
    output logic [`EX_XLEN-1:0]  b
);
    localparam int XLEN = `EX_XLEN;

    always_comb begin
        if (sel_a == ex_pkg::sel_a_rs1) begin
            // word forms see only the low half of rs1
            a = word_a ? {{(XLEN/2){1'b0}}, rs1[XLEN/2-1:0]} : rs1;
        end else begin
            a = pc;
        end
    end

    always_comb begin
        case (sel_b)
            ex_pkg::sel_b_rs2: b = rs2;
            ex_pkg::sel_b_csr: b = csr;
            default:           b = imm;
        endcase
    end

endmodule

`default_nettype wire

/* ex_pkg.sv */
`default_nettype none

package ex_pkg;

    typedef enum logic [4:0] {
        op_add,
        op_sub,
        op_ret_a,
        op_ret_b,
        op_xor,
        op_or,
        op_and,
        op_sll,
        op_srl,
        op_sra,
        op_slt,
        op_sltu,
        op_eq,
        op_ge,
        op_geu,
        op_mul,
        op_div,
        op_divu,
        op_rem,
        op_remu
    } alu_op_t;

    typedef enum logic [1:0] {
        unit_alu,
        unit_mul,
        unit_div
    } unit_t;

    typedef enum logic {
        sel_a_pc,
        sel_a_rs1
    } sel_a_t;

    typedef enum logic [1:0] {
        sel_b_rs2,
        sel_b_csr,
        sel_b_imm
    } sel_b_t;

    // which peer unit executes an operation
    function automatic unit_t op_unit(input alu_op_t op);
        case (op)
            op_mul: return unit_mul;
            op_div, op_divu, op_rem, op_remu: return unit_div;
            default: return unit_alu;
        endcase
    endfunction

endpackage

`default_nettype wire

/* ex_macros.svh */
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// datapath width
`define EX_XLEN 64

// destination register tag
`define EX_TAG_W 5

// multiplier bits consumed per cycle, XLEN / chunk gives the cycle count
`define EX_MUL_CHUNK 16

`endif
